//--- build.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/instr_mem.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/mips_core.sv
tests/tb_mips_core.sv

//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mips_pkg.sv
      - rtl/instr_mem.sv
      - rtl/fetch_unit.sv
      - rtl/decoder.sv
      - rtl/reg_file.sv
      - rtl/alu.sv
      - rtl/mips_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_mips_core.sv

//--- tests/tb_mips_core.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mips_core import mips_pkg::*;
();

    logic                     i_clk;
    logic                     arst_n;
    logic                     load_req;
    logic [`MIPS_IMEM_AW-1:0] load_addr;
    word_t                    load_data;
    logic                     load_ack;
    logic                     run;
    logic                     halted;
    logic                     wb_valid;
    reg_idx_t                 wb_reg;
    word_t                    wb_data;

    // Program image and expected trace
    word_t    prog [`MIPS_IMEM_WORDS];
    int       prog_len;
    reg_idx_t exp_reg_q [$];
    word_t    exp_data_q [$];

    string test_name;
    int    value_errs;
    int    other_errs;
    int    cycle_cnt;
    int    cycle_limit;

    mips_core u_mips_core (
        .i_clk     (i_clk),
        .arst_n    (arst_n),
        .load_req  (load_req),
        .load_addr (load_addr),
        .load_data (load_data),
        .load_ack  (load_ack),
        .run       (run),
        .halted    (halted),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    // 100 ns period
    always #50 i_clk = ~i_clk;

    //////////////////////////////
    // Instruction encoding
    //////////////////////////////
    function automatic word_t rtype_word(logic [5:0] fn, reg_idx_t rd, reg_idx_t rs,
                                         reg_idx_t rt, logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype_word(logic [5:0] op, reg_idx_t rt, reg_idx_t rs,
                                         logic [15:0] imm16);
        return {op, rs, rt, imm16};
    endfunction

    // Unused words read as halt
    function automatic void clear_program();
        prog_len = 0;
        for (int i = 0; i < `MIPS_IMEM_WORDS; i++)
            prog[i] = `MIPS_HALT_WORD;
    endfunction

    function automatic void emit(word_t w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////
    // Walks the program in order from word 0 until the halt word
    function automatic int run_model();
        word_t    regs [32];
        word_t    w;
        word_t    a;
        word_t    b;
        word_t    simm;
        word_t    res;
        reg_idx_t dest;
        logic     wr;
        int       idx;
        int       next;
        int       steps;
        exp_reg_q.delete();
        exp_data_q.delete();
        for (int r = 0; r < 32; r++)
            regs[r] = '0;
        idx   = 0;
        steps = 0;
        while (steps < 256)
        begin
            w = prog[idx];
            if (w == `MIPS_HALT_WORD)
                break;
            a    = regs[w[25:21]];
            b    = regs[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            next = idx + 1;
            wr   = 1'b1;
            dest = w[20:16];
            res  = '0;
            case (w[31:26])
                OP_RTYPE:
                begin
                    dest = w[15:11];
                    case (w[5:0])
                        FN_ADD:  res = a + b;
                        FN_SUB:  res = a - b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_NOR:  res = ~(a | b);
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  res = b << w[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDI: res = a + simm;
                // Zero-extended immediate
                OP_ORI:  res = a | {16'h0000, w[15:0]};
                OP_SLTI: res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                OP_BEQ:
                begin
                    wr = 1'b0;
                    if (a == b)
                        next = idx + 1 + $signed(simm);
                end
                default: wr = 1'b0;
            endcase
            // r0 stays zero and leaves no trace
            if (wr && (dest != '0))
            begin
                regs[dest] = res;
                exp_reg_q.push_back(dest);
                exp_data_q.push_back(res);
            end
            idx = next % `MIPS_IMEM_WORDS;
            steps++;
        end
        return exp_reg_q.size();
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_reg(reg_idx_t expected, reg_idx_t actual);
        if (actual !== expected)
        begin
            value_errs++;
            $display("[ERROR] %s: wb_reg expected %0d, actual %0d", test_name, expected,
                     actual);
        end
    endtask

    task automatic check_word(word_t expected, word_t actual);
        if (actual !== expected)
        begin
            value_errs++;
            $display("[ERROR] %s: wb_data expected %h, actual %h", test_name, expected,
                     actual);
        end
    endtask

    // Trace is sampled mid-cycle at the falling edge
    always @(negedge i_clk)
    begin
        if (arst_n && wb_valid)
        begin
            if (exp_reg_q.size() == 0)
            begin
                other_errs++;
                $display("%s: trace entry r%0d = %h arrived when none was expected",
                         test_name, wb_reg, wb_data);
            end
            else
            begin
                check_reg(exp_reg_q.pop_front(), wb_reg);
                check_word(exp_data_q.pop_front(), wb_data);
            end
        end
    end

    // Cycle budget guard
    always @(posedge i_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit)
        begin
            $display("%s: run stopped after %0d cycles without finishing", test_name,
                     cycle_cnt);
            $display("Errors: %0d value mismatches, %0d other failures", value_errs,
                     other_errs);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // Host side
    //////////////////////////////
    task automatic apply_reset();
        @(posedge i_clk);
        #10;
        arst_n = 1'b0;
        repeat (4) @(posedge i_clk);
        #10;
        arst_n = 1'b1;
    endtask

    // One word through the four-phase handshake
    task automatic send_word(logic [`MIPS_IMEM_AW-1:0] addr, word_t data);
        int waited;
        @(posedge i_clk);
        #10;
        if (load_ack)
        begin
            other_errs++;
            $display("%s: load_ack already high before request at %0d", test_name, addr);
        end
        load_addr = addr;
        load_data = data;
        load_req  = 1'b1;
        waited    = 0;
        while (!load_ack && waited < 4)
        begin
            @(negedge i_clk);
            waited++;
        end
        if (!load_ack)
        begin
            other_errs++;
            $display("%s: load_ack never rose for address %0d", test_name, addr);
        end
        @(posedge i_clk);
        #10;
        load_req = 1'b0;
        waited   = 0;
        while (load_ack && waited < 4)
        begin
            @(negedge i_clk);
            waited++;
        end
        if (load_ack)
        begin
            other_errs++;
            $display("%s: load_ack stuck high after release at %0d", test_name, addr);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++)
            send_word(`MIPS_IMEM_AW'(i), prog[i]);
    endtask

    // Reset, load, run to halt, then look for leftovers
    task automatic execute_test(string name);
        int n;
        int waited;
        test_name   = name;
        cycle_limit = cycle_cnt + prog_len * 4 + 50;
        apply_reset();
        load_program();
        n = run_model();
        $display("%s: %0d words, %0d trace entries expected", name, prog_len, n);
        @(posedge i_clk);
        #10;
        run    = 1'b1;
        waited = 0;
        while (!halted && waited < prog_len * 3 + 10)
        begin
            @(negedge i_clk);
            waited++;
        end
        if (!halted)
        begin
            other_errs++;
            $display("%s: halted never rose", name);
        end
        // Window for stray entries after halt
        repeat (4) @(negedge i_clk);
        if (exp_reg_q.size() != 0)
        begin
            other_errs++;
            $display("%s: %0d trace entries never arrived", name, exp_reg_q.size());
        end
        @(posedge i_clk);
        #10;
        run = 1'b0;
    endtask

    // Forward branches only so that every program reaches its halt
    task automatic random_program(int n);
        int         kind;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [5:0] fn;
        clear_program();
        for (int i = 0; i < n; i++)
        begin
            kind = $urandom % 13;
            rd   = $urandom % 8;
            rs   = $urandom % 8;
            rt   = $urandom % 8;
            case (kind)
                0:       fn = FN_ADD;
                1:       fn = FN_SUB;
                2:       fn = FN_SUBU;
                3:       fn = FN_AND;
                4:       fn = FN_OR;
                5:       fn = FN_NOR;
                6:       fn = FN_XOR;
                default: fn = FN_SLT;
            endcase
            case (kind)
                8:       emit(rtype_word(FN_SLL, rd, 5'd0, rt, 5'($urandom)));
                9:       emit(itype_word(OP_ADDI, rd, rs, 16'($urandom)));
                10:      emit(itype_word(OP_ORI, rd, rs, 16'($urandom)));
                11:      emit(itype_word(OP_SLTI, rd, rs, 16'($urandom)));
                // Target lands at most on the halt word
                12:      emit(itype_word(OP_BEQ, rt, rs, 16'($urandom % (n - i))));
                default: emit(rtype_word(fn, rd, rs, rt, 5'd0));
            endcase
        end
        emit(`MIPS_HALT_WORD);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial
    begin
        i_clk       = 1'b0;
        arst_n      = 1'b0;
        load_req    = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        run         = 1'b0;
        value_errs  = 0;
        other_errs  = 0;
        cycle_cnt   = 0;
        cycle_limit = 100;
        test_name   = "init";
        void'($urandom(32'ha534_a90d));

        // Handshake and readback through execution
        clear_program();
        emit(itype_word(OP_ADDI, 5'd1, 5'd0, 16'h1234));
        emit(itype_word(OP_ORI, 5'd2, 5'd0, 16'hbeef));
        emit(`MIPS_HALT_WORD);
        execute_test("load_handshake");

        // R-type ops on a negative and a positive operand
        clear_program();
        emit(itype_word(OP_ADDI, 5'd1, 5'd0, 16'hfffb));
        emit(itype_word(OP_ADDI, 5'd2, 5'd0, 16'h0007));
        emit(rtype_word(FN_ADD, 5'd3, 5'd1, 5'd2, 5'd0));
        emit(rtype_word(FN_SUB, 5'd4, 5'd1, 5'd2, 5'd0));
        emit(rtype_word(FN_SUBU, 5'd5, 5'd2, 5'd1, 5'd0));
        emit(rtype_word(FN_AND, 5'd6, 5'd1, 5'd2, 5'd0));
        emit(rtype_word(FN_OR, 5'd7, 5'd1, 5'd2, 5'd0));
        emit(rtype_word(FN_NOR, 5'd8, 5'd1, 5'd2, 5'd0));
        emit(rtype_word(FN_XOR, 5'd9, 5'd1, 5'd2, 5'd0));
        emit(rtype_word(FN_SLT, 5'd10, 5'd1, 5'd2, 5'd0));
        emit(rtype_word(FN_SLT, 5'd11, 5'd2, 5'd1, 5'd0));
        emit(`MIPS_HALT_WORD);
        execute_test("rtype_alu");

        // Extension rules, shifts, r0 writes
        clear_program();
        emit(itype_word(OP_ADDI, 5'd1, 5'd0, 16'h8000));
        emit(itype_word(OP_SLTI, 5'd2, 5'd1, 16'hffff));
        emit(itype_word(OP_SLTI, 5'd3, 5'd0, 16'h8000));
        emit(itype_word(OP_ORI, 5'd4, 5'd0, 16'h8001));
        emit(rtype_word(FN_SLL, 5'd5, 5'd0, 5'd4, 5'd4));
        emit(itype_word(OP_ADDI, 5'd0, 5'd0, 16'd99));
        emit(rtype_word(FN_OR, 5'd6, 5'd0, 5'd0, 5'd0));
        emit(rtype_word(FN_SLL, 5'd7, 5'd0, 5'd4, 5'd31));
        emit(`MIPS_HALT_WORD);
        execute_test("imm_shift");

        // Taken, not taken, and taken onto the killed slot
        clear_program();
        emit(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd3));
        emit(itype_word(OP_ADDI, 5'd2, 5'd0, 16'd3));
        emit(itype_word(OP_BEQ, 5'd2, 5'd1, 16'd1));
        emit(itype_word(OP_ADDI, 5'd3, 5'd0, 16'd111));
        emit(itype_word(OP_ADDI, 5'd4, 5'd0, 16'd222));
        emit(itype_word(OP_BEQ, 5'd0, 5'd1, 16'd1));
        emit(itype_word(OP_ADDI, 5'd5, 5'd0, 16'd333));
        emit(itype_word(OP_BEQ, 5'd0, 5'd0, 16'd0));
        emit(itype_word(OP_ADDI, 5'd6, 5'd0, 16'd444));
        emit(`MIPS_HALT_WORD);
        execute_test("branch");

        // Words behind the halt must never retire
        clear_program();
        emit(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd1));
        emit(`MIPS_HALT_WORD);
        emit(itype_word(OP_ADDI, 5'd2, 5'd0, 16'd2));
        emit(itype_word(OP_ADDI, 5'd3, 5'd0, 16'd3));
        execute_test("halt");

        for (int t = 0; t < 20; t++)
        begin
            random_program(6 + $urandom % 10);
            execute_test($sformatf("random_%0d", t));
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- rtl/mips_core.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_core import mips_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     arst_n,
    input  logic                     load_req,
    input  logic [`MIPS_IMEM_AW-1:0] load_addr,
    input  word_t                    load_data,
    output logic                     load_ack,
    input  logic                     run,
    output logic                     halted,
    output logic                     wb_valid,
    output reg_idx_t                 wb_reg,
    output word_t                    wb_data
);

    word_t      pc;
    word_t      exec_pc;
    word_t      instr;
    logic       instr_valid;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd_dest;
    alu_op_e    alu_op;
    logic       use_imm;
    word_t      imm;
    logic [4:0] shamt;
    logic       reg_write;
    logic       is_branch;
    logic       is_halt;
    word_t      rs_data;
    word_t      rt_data;
    word_t      alu_b;
    word_t      alu_result;
    logic       alu_zero;
    logic       we;
    logic       branch_taken;
    word_t      branch_target;

    //////////////////////////////
    // Fetch and instruction memory
    //////////////////////////////
    // Host loads only while stopped
    instr_mem u_instr_mem (
        .i_clk     (i_clk),
        .arst_n    (arst_n),
        .load_req  (load_req && !run),
        .load_addr (load_addr),
        .load_data (load_data),
        .load_ack  (load_ack),
        .rd_addr   (pc[`MIPS_IMEM_AW+1:2]),
        .rd_data   (instr)
    );

    fetch_unit u_fetch_unit (
        .i_clk         (i_clk),
        .arst_n        (arst_n),
        .run           (run),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halt_seen     (instr_valid && is_halt),
        .pc            (pc),
        .exec_pc       (exec_pc),
        .instr_valid   (instr_valid),
        .halted        (halted)
    );

    //////////////////////////////
    // Execute
    //////////////////////////////
    decoder u_decoder (
        .instr     (instr),
        .rs        (rs),
        .rt        (rt),
        .rd_dest   (rd_dest),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .imm       (imm),
        .shamt     (shamt),
        .reg_write (reg_write),
        .is_branch (is_branch),
        .is_halt   (is_halt)
    );

    // Killed slots write nothing
    assign we = instr_valid && reg_write;

    reg_file u_reg_file (
        .i_clk   (i_clk),
        .arst_n  (arst_n),
        .rs      (rs),
        .rt      (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .we      (we),
        .wr_reg  (rd_dest),
        .wr_data (alu_result)
    );

    // Operand B mux
    assign alu_b = use_imm ? imm : rt_data;

    alu u_alu (
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (shamt),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // Target is pc + 4 + offset words
    assign branch_target = exec_pc + 32'd4 + {imm[29:0], 2'b00};
    assign branch_taken  = instr_valid && is_branch && alu_zero;

    //////////////////////////////
    // Trace port, one cycle after execute
    //////////////////////////////
    always_ff @(posedge i_clk or negedge arst_n)
    begin
        if (!arst_n)
            wb_valid <= 1'b0;
        else
            // r0 writes are not reported
            wb_valid <= we && (rd_dest != '0);
    end

    always_ff @(posedge i_clk)
    begin
        if (we)
        begin
            wb_reg  <= rd_dest;
            wb_data <= alu_result;
        end
    end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*;
(
    input  word_t      a,
    input  word_t      b,
    input  logic [4:0] shamt,
    input  alu_op_e    op,
    output word_t      result,
    output logic       zero
);

    logic a_lt_b;

    // Signed compare for SLT and SLTI
    assign a_lt_b = ($signed(a) < $signed(b));

    //////////////////////////////
    // Operation select
    //////////////////////////////
    always_comb
    begin
        case (op)
            // Wraps modulo 2^32
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_NOR: result = ~(a | b);
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'd0, a_lt_b};
            // Shift operand is rt, not rs
            ALU_SLL: result = b << shamt;
            default: result = '0;
        endcase
    end

    // Used by BEQ with op sub
    assign zero = (result == '0);

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file import mips_pkg::*;
(
    input  logic     i_clk,
    input  logic     arst_n,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    output word_t    rs_data,
    output word_t    rt_data,
    input  logic     we,
    input  reg_idx_t wr_reg,
    input  word_t    wr_data
);

    word_t regs [32];

    // Write port, r0 never stored
    always_ff @(posedge i_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && (wr_reg != '0))
        begin
            regs[wr_reg] <= wr_data;
        end
    end

    // Combinational reads
    // r0 forced to zero
    assign rs_data = (rs == '0) ? '0 : regs[rs];
    assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

//--- rtl/decoder.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module decoder import mips_pkg::*;
(
    input  word_t    instr,
    output reg_idx_t rs,
    output reg_idx_t rt,
    output reg_idx_t rd_dest,
    output alu_op_e  alu_op,
    output logic     use_imm,
    output word_t    imm,
    output logic [4:0] shamt,
    output logic     reg_write,
    output logic     is_branch,
    output logic     is_halt
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    reg_idx_t    rd_field;

    // Instruction fields
    assign opcode   = instr[31:26];
    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign rd_field = instr[15:11];
    assign shamt    = instr[10:6];
    assign funct    = instr[5:0];
    assign imm16    = instr[15:0];

    assign is_halt = (instr == `MIPS_HALT_WORD);

    //////////////////////////////
    // Control decode
    //////////////////////////////
    always_comb
    begin
        // Defaults give a no-op
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        is_branch = 1'b0;
        rd_dest   = rt;
        // Sign extension unless ORI
        imm       = {{16{imm16[15]}}, imm16};

        case (opcode)
            OP_RTYPE:
            begin
                rd_dest   = rd_field;
                reg_write = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    // SUBU differs from SUB only in trapping, which is not done
                    FN_SUB,
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDI:
            begin
                alu_op    = ALU_ADD;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_ORI:
            begin
                alu_op    = ALU_OR;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                imm       = {16'h0000, imm16};
            end
            OP_SLTI:
            begin
                alu_op    = ALU_SLT;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_BEQ:
            begin
                // rs minus rt, zero flag decides
                alu_op    = ALU_SUB;
                is_branch = 1'b1;
            end
            default:
            begin
                reg_write = 1'b0;
                is_branch = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import mips_pkg::*;
(
    input  logic  i_clk,
    input  logic  arst_n,
    input  logic  run,
    input  logic  branch_taken,
    input  word_t branch_target,
    input  logic  halt_seen,
    output word_t pc,
    output word_t exec_pc,
    output logic  instr_valid,
    output logic  halted
);

    logic fetch_en;

    // Fetch stops at the same edge the halt word executes
    assign fetch_en = run && !halted && !halt_seen;

    //////////////////////////////
    // PC and execute-slot tracking
    //////////////////////////////
    always_ff @(posedge i_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc          <= '0;
            exec_pc     <= '0;
            instr_valid <= 1'b0;
            halted      <= 1'b0;
        end
        else
        begin
            // Sticky until reset
            if (halt_seen)
                halted <= 1'b1;

            if (fetch_en)
            begin
                // Word read at this edge belongs to the current pc
                exec_pc     <= pc;
                // Slot behind a taken branch is killed
                instr_valid <= !branch_taken;
                if (branch_taken)
                    pc <= branch_target;
                else
                    pc <= pc + 32'd4;
            end
            else
            begin
                instr_valid <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/instr_mem.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module instr_mem import mips_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     arst_n,
    input  logic                     load_req,
    input  logic [`MIPS_IMEM_AW-1:0] load_addr,
    input  word_t                    load_data,
    output logic                     load_ack,
    input  logic [`MIPS_IMEM_AW-1:0] rd_addr,
    output word_t                    rd_data
);

    // Load handshake phases
    typedef enum logic {
        LD_IDLE,
        LD_ACK
    } ld_state_e;

    ld_state_e ld_state;
    logic      ld_write;
    word_t     mem [`MIPS_IMEM_WORDS];

    // Word is taken on the first edge that sees the request
    assign ld_write = (ld_state == LD_IDLE) && load_req;
    assign load_ack = (ld_state == LD_ACK);

    //////////////////////////////
    // Four-phase load FSM
    //////////////////////////////
    always_ff @(posedge i_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ld_state <= LD_IDLE;
        end
        else
        begin
            case (ld_state)
                LD_IDLE: if (load_req) ld_state <= LD_ACK;
                // Hold ack until the host lets go of req
                LD_ACK:  if (!load_req) ld_state <= LD_IDLE;
                default: ld_state <= LD_IDLE;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge i_clk)
    begin
        if (ld_write)
            mem[load_addr] <= load_data;
    end

    //////////////////////////////
    // Registered read, one cycle
    //////////////////////////////
    always_ff @(posedge i_clk or negedge arst_n)
    begin
        if (!arst_n)
            // All zero decodes as sll r0, a NOP
            rd_data <= '0;
        else
            rd_data <= mem[rd_addr];
    end

endmodule

//--- rtl/mips_pkg.sv
package mips_pkg;

    // Machine word and register index
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL
    } alu_op_e;

    //////////////////////////////
    // Opcode field, bits 31:26
    //////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_SLTI  = 6'b001010;
    localparam logic [5:0] OP_BEQ   = 6'b000100;

    //////////////////////////////
    // Funct field for R-type, bits 5:0
    //////////////////////////////
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;

endpackage

//--- rtl/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Instruction memory depth in 32-bit words
`define MIPS_IMEM_WORDS 64

// Word address width, log2 of the depth
`define MIPS_IMEM_AW 6

// All-ones word stops the core when it reaches execute
`define MIPS_HALT_WORD 32'hFFFF_FFFF

`endif
